// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module cpu_tb -o cpu_tb_sim
output=$(./obj_dir/cpu_tb_sim)
echo "$output"

if echo "$output" | grep -qxF "STATUS: PASS"; then
  exit 0
else
  exit 1
fi

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;

  localparam int run_timeout = 100;

  logic clk = 1'b0;
  logic rst_n;
  logic start;
  logic imem_we;
  logic [core_pkg::pc_width-1:0] imem_addr;
  logic [isa_pkg::instr_width-1:0] imem_data;
  logic busy;
  logic wb_valid;
  logic [isa_pkg::reg_addr_width-1:0] wb_addr;
  logic [isa_pkg::data_width-1:0] wb_data;
  logic done;
  logic [core_pkg::count_width-1:0] cycle_count;

  int mismatch_count = 0;
  int timeout_count = 0;
  int file_errors = 0;
  int runs_done = 0;
  integer seed;

  // expected write-backs of the current run, in program order
  logic [isa_pkg::reg_addr_width-1:0] exp_reg_q[$];
  logic [isa_pkg::data_width-1:0] exp_val_q[$];

  cpu_top cpu_top_i (
    .clk(clk),
    .rst_n(rst_n),
    .start(start),
    .imem_we(imem_we),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .busy(busy),
    .wb_valid(wb_valid),
    .wb_addr(wb_addr),
    .wb_data(wb_data),
    .done(done),
    .cycle_count(cycle_count)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, actual, expected);
      mismatch_count++;
    end
  endtask

  task automatic expect_fields(input int got, input int want, input logic [7:0] rec);
    if (got != want) begin
      $display("golden file record %s has %0d fields instead of %0d", rec, got, want);
      file_errors++;
    end
  endtask

  task automatic load_word(input logic [core_pkg::pc_width-1:0] addr,
                           input logic [isa_pkg::instr_width-1:0] word);
    @(posedge clk);
    imem_we <= 1'b1;
    imem_addr <= addr;
    imem_data <= word;
  endtask

  task automatic run_program(input int exp_count);
    int cyc;
    bit finished;
    cyc = 0;
    finished = 1'b0;
    @(posedge clk);
    imem_we <= 1'b0;
    start <= 1'b1;
    while (!finished && cyc < run_timeout) begin
      @(posedge clk);
      // a second start while busy
      start <= (cyc == 1);
      @(negedge clk);
      check_value(32'(busy), 32'd1, "busy during run");
      if (wb_valid) begin
        if (exp_reg_q.size() == 0) begin
          $display("ERR %0t: unexpected write-back to r%0d", $time, wb_addr);
          mismatch_count++;
        end else begin
          check_value(32'(wb_addr), 32'(exp_reg_q.pop_front()), "write-back register");
          check_value(wb_data, exp_val_q.pop_front(), "write-back data");
        end
      end
      if (done) begin
        check_value(32'(cycle_count), exp_count, "cycle count at done");
        // done cycle counted from the first run cycle
        check_value(cyc + 1, exp_count, "cycles from start to done");
        finished = 1'b1;
      end
      cyc++;
    end
    if (!finished) begin
      $display("timeout: done did not arrive within %0d cycles of start", run_timeout);
      timeout_count++;
    end
  endtask

  // random quiet gap between runs
  task automatic idle_and_watch();
    int cycles;
    cycles = 1 + ($random(seed) & 7);
    repeat (cycles) begin
      @(negedge clk);
      check_value(32'(busy), 32'd0, "busy after done");
      check_value(32'(wb_valid), 32'd0, "wb_valid outside a run");
      check_value(32'(done), 32'd0, "done outside a run");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int fd;
    int n;
    int c;
    int count;
    bit reading;
    bit run_open;
    logic [7:0] rec;
    logic [core_pkg::pc_width-1:0] addr;
    logic [isa_pkg::instr_width-1:0] word;
    logic [isa_pkg::reg_addr_width-1:0] reg_idx;
    logic [isa_pkg::data_width-1:0] value;

    seed = 32'h450d;
    rst_n <= 1'b0;
    start <= 1'b0;
    imem_we <= 1'b0;
    imem_addr <= '0;
    imem_data <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value(32'(busy), 32'd0, "busy after reset");
    check_value(32'(wb_valid), 32'd0, "wb_valid after reset");
    check_value(32'(done), 32'd0, "done after reset");

    fd = $fopen("sim/golden_program.txt", "r");
    if (fd == 0) begin
      $display("cannot open sim/golden_program.txt");
      file_errors++;
    end else begin
      reading = 1'b1;
      run_open = 1'b0;
      while (reading) begin
        n = $fscanf(fd, " %c", rec);
        if (n != 1) begin
          reading = 1'b0;
        end else if (rec == "#") begin
          c = $fgetc(fd);
          while (c != 10 && c != -1) begin
            c = $fgetc(fd);
          end
        end else if (rec == "L") begin
          n = $fscanf(fd, "%h %h", addr, word);
          expect_fields(n, 2, rec);
          load_word(addr, word);
        end else if (rec == "S") begin
          run_open = 1'b1;
        end else if (rec == "W") begin
          n = $fscanf(fd, "%d %h", reg_idx, value);
          expect_fields(n, 2, rec);
          exp_reg_q.push_back(reg_idx);
          exp_val_q.push_back(value);
        end else if (rec == "D") begin
          n = $fscanf(fd, "%d", count);
          expect_fields(n, 1, rec);
          if (!run_open) begin
            $display("golden file has a done record with no start record before it");
            file_errors++;
          end else begin
            run_program(count);
            check_value(32'(exp_reg_q.size()), 32'd0, "write-backs still missing");
            idle_and_watch();
            exp_reg_q.delete();
            exp_val_q.delete();
            run_open = 1'b0;
            runs_done++;
          end
        end else begin
          $display("golden file has an unknown record type %s", rec);
          file_errors++;
          reading = 1'b0;
        end
      end
      $fclose(fd);
    end

    if (runs_done == 0) begin
      $display("no run was executed from the golden file");
      file_errors++;
    end
    $display("errors: %0d mismatches, %0d timeouts, %0d file errors",
             mismatch_count, timeout_count, file_errors);
    if (mismatch_count + timeout_count + file_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/golden_program.txt ====
# columns: L addr(hex) word(hex) | S | W reg(dec) value(hex) | D cycle_count(dec)
# W records are the expected write-backs of the run in program order
# run 1: addi with top immediate bit set, dependent alu chain
L 00 20018001
L 01 200200ff
L 02 04221800
L 03 08612000
L 04 0c812800
L 05 10a33000
L 06 14c53800
L 07 fc000000
L 08 20081234
S
W 1 00008001
W 2 000000ff
W 3 00008100
W 4 000000ff
W 5 00000001
W 6 00008101
W 7 00008100
D 11
# run 2: nop, write to r0, read of r0, registers from run 1
L 00 00000000
L 01 20e00005
L 02 04074000
L 03 09064800
L 04 0d225000
L 05 fc000000
L 06 200b0001
S
W 8 00008100
W 9 ffffffff
W 10 000000ff
D 9
# run 3: addi chain on one register, xor and or with forwarding
L 00 214bff00
L 01 216bffff
L 02 15696000
L 03 118b6800
L 04 05a10800
L 05 fc000000
S
W 11 0000ffff
W 11 0001fffe
W 12 fffe0001
W 13 ffffffff
W 1 00008000
D 9

// ==== source/core_pkg.sv ====
package core_pkg;

  localparam int imem_depth = 64;
  localparam int pc_width = $clog2(imem_depth);

  // cycles from the halt decode until the last write-back
  localparam int drain_cycles = 2;
  localparam int drain_width = $clog2(drain_cycles + 1);

  localparam int count_width = 16;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_run   = 2'd1,
    st_drain = 2'd2
  } run_state_e;

endpackage

// ==== source/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic imem_we,
  input  logic [core_pkg::pc_width-1:0] imem_addr,
  input  logic [isa_pkg::instr_width-1:0] imem_data,
  output logic busy,
  output logic wb_valid,
  output logic [isa_pkg::reg_addr_width-1:0] wb_addr,
  output logic [isa_pkg::data_width-1:0] wb_data,
  output logic done,
  output logic [core_pkg::count_width-1:0] cycle_count
);

  logic fetch_en, clear_pc, drain_start, drain_done, halt_seen;
  logic [isa_pkg::instr_width-1:0] instr;
  logic instr_valid;
  logic [isa_pkg::reg_addr_width-1:0] rs_addr, rt_addr;
  logic [isa_pkg::data_width-1:0] rs_data, rt_data;
  isa_pkg::opcode_e ex_op;
  logic [isa_pkg::data_width-1:0] ex_a, ex_b;
  logic [isa_pkg::reg_addr_width-1:0] ex_rs, ex_rt_src, ex_dst;
  logic ex_uses_imm, ex_write;

  run_control run_control_i (
    .clk(clk), .rst_n(rst_n), .start(start), .halt_seen(halt_seen),
    .drain_done(drain_done), .fetch_en(fetch_en), .clear_pc(clear_pc),
    .drain_start(drain_start), .busy(busy)
  );

  run_timer run_timer_i (
    .clk(clk), .rst_n(rst_n), .busy(busy), .drain_start(drain_start),
    .drain_done(drain_done), .done(done), .cycle_count(cycle_count)
  );

  fetch_stage fetch_stage_i (
    .clk(clk), .rst_n(rst_n), .fetch_en(fetch_en), .clear_pc(clear_pc),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
    .instr(instr), .instr_valid(instr_valid)
  );

  decode_stage decode_stage_i (
    .clk(clk), .rst_n(rst_n), .instr(instr), .instr_valid(instr_valid),
    .halt_seen(halt_seen), .rs_addr(rs_addr), .rt_addr(rt_addr),
    .rs_data(rs_data), .rt_data(rt_data), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b),
    .ex_rs(ex_rs), .ex_rt_src(ex_rt_src), .ex_dst(ex_dst),
    .ex_uses_imm(ex_uses_imm), .ex_write(ex_write)
  );

  register_file register_file_i (
    .clk(clk), .rst_n(rst_n), .wb_valid(wb_valid), .wb_addr(wb_addr),
    .wb_data(wb_data), .rs_addr(rs_addr), .rt_addr(rt_addr),
    .rs_data(rs_data), .rt_data(rt_data)
  );

  execute_stage execute_stage_i (
    .clk(clk), .rst_n(rst_n), .ex_op(ex_op), .ex_a(ex_a), .ex_b(ex_b),
    .ex_rs(ex_rs), .ex_rt_src(ex_rt_src), .ex_dst(ex_dst),
    .ex_uses_imm(ex_uses_imm), .ex_write(ex_write),
    .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
  );

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic [isa_pkg::instr_width-1:0] instr,
  input  logic instr_valid,
  output logic halt_seen,
  output logic [isa_pkg::reg_addr_width-1:0] rs_addr,
  output logic [isa_pkg::reg_addr_width-1:0] rt_addr,
  input  logic [isa_pkg::data_width-1:0] rs_data,
  input  logic [isa_pkg::data_width-1:0] rt_data,
  output isa_pkg::opcode_e ex_op,
  output logic [isa_pkg::data_width-1:0] ex_a,
  output logic [isa_pkg::data_width-1:0] ex_b,
  output logic [isa_pkg::reg_addr_width-1:0] ex_rs,
  output logic [isa_pkg::reg_addr_width-1:0] ex_rt_src,
  output logic [isa_pkg::reg_addr_width-1:0] ex_dst,
  output logic ex_uses_imm,
  output logic ex_write
);

  isa_pkg::opcode_e op;
  logic [isa_pkg::reg_addr_width-1:0] rd;
  logic [isa_pkg::reg_addr_width-1:0] dst;
  logic [isa_pkg::imm_width-1:0] imm;
  logic [isa_pkg::data_width-1:0] imm_ext;
  logic uses_imm;
  logic writes;
  logic dec_write;

  ////////////////////////////////////////////////////////////////////////////
  // field split

  assign op = isa_pkg::opcode_e'(instr[isa_pkg::opcode_msb:isa_pkg::opcode_lsb]);
  assign rs_addr = instr[isa_pkg::rs_lsb +: isa_pkg::reg_addr_width];
  assign rt_addr = instr[isa_pkg::rt_lsb +: isa_pkg::reg_addr_width];
  assign rd = instr[isa_pkg::rd_lsb +: isa_pkg::reg_addr_width];
  assign imm = instr[isa_pkg::imm_width-1:0];
  assign imm_ext = {{(isa_pkg::data_width - isa_pkg::imm_width){1'b0}}, imm};

  assign halt_seen = instr_valid && (op == isa_pkg::op_halt);

  ////////////////////////////////////////////////////////////////////////////
  // control decode

  always_comb begin
    uses_imm = 1'b0;
    dst = rd;
    writes = 1'b0;
    case (op)
      isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and,
      isa_pkg::op_or, isa_pkg::op_xor: begin
        writes = 1'b1;
      end
      isa_pkg::op_addi: begin
        uses_imm = 1'b1;
        dst = rt_addr;
        writes = 1'b1;
      end
      // nop, halt and unknown codes
      default: writes = 1'b0;
    endcase
  end

  assign dec_write = instr_valid && writes && (dst != '0);

  ////////////////////////////////////////////////////////////////////////////
  // decode to execute register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_op <= isa_pkg::op_nop;
      ex_write <= 1'b0;
    end else begin
      // no-write slots (halt included) travel on as bubbles
      ex_op <= dec_write ? op : isa_pkg::op_nop;
      ex_write <= dec_write;
    end
  end

  always_ff @(posedge clk) begin
    ex_a <= rs_data;
    ex_b <= uses_imm ? imm_ext : rt_data;
    ex_rs <= rs_addr;
    ex_rt_src <= rt_addr;
    ex_dst <= dst;
    ex_uses_imm <= uses_imm;
  end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage (
  input  logic clk,
  input  logic rst_n,
  input  isa_pkg::opcode_e ex_op,
  input  logic [isa_pkg::data_width-1:0] ex_a,
  input  logic [isa_pkg::data_width-1:0] ex_b,
  input  logic [isa_pkg::reg_addr_width-1:0] ex_rs,
  input  logic [isa_pkg::reg_addr_width-1:0] ex_rt_src,
  input  logic [isa_pkg::reg_addr_width-1:0] ex_dst,
  input  logic ex_uses_imm,
  input  logic ex_write,
  output logic wb_valid,
  output logic [isa_pkg::reg_addr_width-1:0] wb_addr,
  output logic [isa_pkg::data_width-1:0] wb_data
);

  logic fwd_a;
  logic fwd_b;
  logic [isa_pkg::data_width-1:0] op_a;
  logic [isa_pkg::data_width-1:0] op_b;
  logic [isa_pkg::data_width-1:0] result;

  ////////////////////////////////////////////////////////////////////////////
  // forwarding from the write-back register

  assign fwd_a = wb_valid && (wb_addr == ex_rs);
  // ex_b already holds the immediate for addi
  assign fwd_b = wb_valid && (wb_addr == ex_rt_src) && !ex_uses_imm;

  assign op_a = fwd_a ? wb_data : ex_a;
  assign op_b = fwd_b ? wb_data : ex_b;

  ////////////////////////////////////////////////////////////////////////////
  // alu

  always_comb begin
    case (ex_op)
      isa_pkg::op_add:  result = op_a + op_b;
      isa_pkg::op_addi: result = op_a + op_b;
      isa_pkg::op_sub:  result = op_a - op_b;
      isa_pkg::op_and:  result = op_a & op_b;
      isa_pkg::op_or:   result = op_a | op_b;
      isa_pkg::op_xor:  result = op_a ^ op_b;
      default:          result = '0;
    endcase
  end

  // write-back register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_write;
    end
  end

  always_ff @(posedge clk) begin
    wb_addr <= ex_dst;
    wb_data <= result;
  end

endmodule

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
  input  logic clk,
  input  logic rst_n,
  input  logic fetch_en,
  input  logic clear_pc,
  input  logic imem_we,
  input  logic [core_pkg::pc_width-1:0] imem_addr,
  input  logic [isa_pkg::instr_width-1:0] imem_data,
  output logic [isa_pkg::instr_width-1:0] instr,
  output logic instr_valid
);

  logic [isa_pkg::instr_width-1:0] imem [core_pkg::imem_depth];
  logic [core_pkg::pc_width-1:0] pc;

  // program load port
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= fetch_en;
      if (clear_pc) begin
        pc <= '0;
      end else if (fetch_en) begin
        pc <= pc + 1;
      end
    end
  end

  // fetch register
  always_ff @(posedge clk) begin
    if (fetch_en) begin
      instr <= imem[pc];
    end
  end

endmodule

// ==== source/isa_pkg.sv ====
package isa_pkg;

  localparam int instr_width = 32;
  localparam int data_width = 32;

  // instruction fields
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int rs_lsb = 21;
  localparam int rt_lsb = 16;
  localparam int rd_lsb = 11;
  localparam int imm_width = 16;

  localparam int reg_addr_width = 5;
  localparam int num_regs = 32;

  typedef enum logic [5:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_addi = 6'h08,
    op_halt = 6'h3f
  } opcode_e;

endpackage

// ==== source/register_file.sv ====
`timescale 1ns/1ns

module register_file (
  input  logic clk,
  input  logic rst_n,
  input  logic wb_valid,
  input  logic [isa_pkg::reg_addr_width-1:0] wb_addr,
  input  logic [isa_pkg::data_width-1:0] wb_data,
  input  logic [isa_pkg::reg_addr_width-1:0] rs_addr,
  input  logic [isa_pkg::reg_addr_width-1:0] rt_addr,
  output logic [isa_pkg::data_width-1:0] rs_data,
  output logic [isa_pkg::data_width-1:0] rt_data
);

  logic [isa_pkg::data_width-1:0] regs [isa_pkg::num_regs];

  // r0 reads zero and a same-cycle write passes straight through
  function automatic logic [isa_pkg::data_width-1:0] read_port(
    input logic [isa_pkg::reg_addr_width-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (wb_valid && (wb_addr == addr)) begin
      return wb_data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < isa_pkg::num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && (wb_addr != '0)) begin
      regs[wb_addr] <= wb_data;
    end
  end

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

endmodule

// ==== source/run_control.sv ====
`timescale 1ns/1ns

module run_control (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic halt_seen,
  input  logic drain_done,
  output logic fetch_en,
  output logic clear_pc,
  output logic drain_start,
  output logic busy
);

  core_pkg::run_state_e state;
  core_pkg::run_state_e state_next;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= core_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    fetch_en = 1'b0;
    clear_pc = 1'b0;
    drain_start = 1'b0;
    case (state)
      core_pkg::st_idle: begin
        // start outside idle is dropped
        if (start) begin
          state_next = core_pkg::st_run;
          clear_pc = 1'b1;
        end
      end
      core_pkg::st_run: begin
        fetch_en = !halt_seen;
        if (halt_seen) begin
          state_next = core_pkg::st_drain;
          drain_start = 1'b1;
        end
      end
      core_pkg::st_drain: begin
        if (drain_done) begin
          state_next = core_pkg::st_idle;
        end
      end
      default: state_next = core_pkg::st_idle;
    endcase
  end

  assign busy = (state != core_pkg::st_idle);

endmodule

// ==== source/run_timer.sv ====
`timescale 1ns/1ns

module run_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic busy,
  input  logic drain_start,
  output logic drain_done,
  output logic done,
  output logic [core_pkg::count_width-1:0] cycle_count
);

  logic busy_d;
  logic [core_pkg::drain_width-1:0] drain_cnt;
  logic [core_pkg::count_width-1:0] run_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_d <= 1'b0;
      drain_cnt <= '0;
      run_cnt <= '0;
    end else begin
      busy_d <= busy;
      // first busy cycle is already one cycle of the run
      if (busy && !busy_d) begin
        run_cnt <= 1;
      end else if (busy) begin
        run_cnt <= run_cnt + 1;
      end
      if (drain_start) begin
        drain_cnt <= core_pkg::drain_cycles[core_pkg::drain_width-1:0];
      end else if (drain_cnt != '0) begin
        drain_cnt <= drain_cnt - 1;
      end
    end
  end

  assign drain_done = (drain_cnt == 1);
  assign done = drain_done;

  // count through the current cycle
  assign cycle_count = run_cnt + 1;

endmodule

// ==== tb.f ====
source/isa_pkg.sv
source/core_pkg.sv
source/run_control.sv
source/run_timer.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/cpu_top.sv
sim/cpu_tb.sv
